/* bench/ctrlRefModel.svh */
`ifndef CTRL_REF_MODEL_SVH
`define CTRL_REF_MODEL_SVH

// one instruction window, from its irWrite up to the next irWrite
typedef struct packed {
    int         period;
    int         regWrites;
    regDstE     regDst;
    memToRegE   memToReg;
    int         memWrites;
    int         pcWrites;    // fetch write included
    pcSrcE      jumpSrc;     // pcSrc of the first pcWrite
    int         condWrites;
    branchCondE branchCond;
    aluOpE      branchAluOp;
    int         epcWrites;
    iorDE       epcAddr;
    int         multInits;
    int         hiLoWrites;
    int         hiLoDelay;   // multInit to hiLoWrite
    int         aLoads;
    int         bLoads;
    int         srcASelects;
    int         aluOutWrites;
    aluSrcBE    aluOutSrcB;  // aluSrcB of the last aluOutWrite
    int         mdrLoads;
} expectT;

function automatic expectT blankRecord();
    expectT e;
    e.period       = 0;
    e.regWrites    = 0;
    e.regDst       = dstRt;
    e.memToReg     = wbAluOut;
    e.memWrites    = 0;
    e.pcWrites     = 0;
    e.jumpSrc      = pcAluResult;
    e.condWrites   = 0;
    e.branchCond   = brNone;
    e.branchAluOp  = aluPass;
    e.epcWrites    = 0;
    e.epcAddr      = adrPc;
    e.multInits    = 0;
    e.hiLoWrites   = 0;
    e.hiLoDelay    = 0;
    e.aLoads       = 0;
    e.bLoads       = 0;
    e.srcASelects  = 0;
    e.aluOutWrites = 0;
    e.aluOutSrcB   = srcBRegB;
    e.mdrLoads     = 0;
    return e;
endfunction

function automatic expectT expectedFor(instrClassE cls, bit ovf, int multCycles);
    expectT e;
    e = blankRecord();
    e.pcWrites     = 1; // pc + 4 in fetchPc
    e.aLoads       = 1; // operands latched in decode
    e.bLoads       = 1;
    e.aluOutWrites = 1; // branch target in decode
    e.aluOutSrcB   = srcBBranchOff;
    case (cls)
        clsAdd, clsAddi, clsAddiu: begin
            e.period       = 6;
            e.regWrites    = 1;
            e.regDst       = (cls == clsAdd) ? dstRd : dstRt;
            e.srcASelects  = 1;
            e.aluOutWrites = 2;
            e.aluOutSrcB   = (cls == clsAdd) ? srcBRegB : srcBImm;
        end
        clsLw: begin
            e.period       = 9;
            e.regWrites    = 1;
            e.memToReg     = wbMdr;
            e.srcASelects  = 1;
            e.aluOutWrites = 2;
            e.aluOutSrcB   = srcBImm;
            e.mdrLoads     = 1;
        end
        clsSw: begin
            e.period       = 6;
            e.memWrites    = 1;
            e.srcASelects  = 1;
            e.aluOutWrites = 2;
            e.aluOutSrcB   = srcBImm;
        end
        clsBeq, clsBne, clsBgt, clsBle: begin
            e.period      = 5;
            e.condWrites  = 1;
            e.srcASelects = 1;
            e.branchAluOp = (cls == clsBeq || cls == clsBne) ? aluSub : aluCompare;
            case (cls)
                clsBeq:  e.branchCond = brEq;
                clsBne:  e.branchCond = brNe;
                clsBgt:  e.branchCond = brGt;
                default: e.branchCond = brLe;
            endcase
        end
        clsJ, clsJr: begin
            e.period      = 5;
            e.pcWrites    = 2;
            e.jumpSrc     = (cls == clsJ) ? pcJumpTarget : pcAluResult;
            e.srcASelects = (cls == clsJr) ? 1 : 0; // rs through the alu
        end
        clsJal: begin
            e.period    = 6;
            e.regWrites = 1;
            e.regDst    = dstRa;
            e.memToReg  = wbPcLink;
            e.pcWrites  = 2;
            e.jumpSrc   = pcJumpTarget;
        end
        clsMult: begin
            e.period     = 6 + multCycles;
            e.multInits  = 1;
            e.hiLoWrites = 1;
            e.hiLoDelay  = multCycles + 1;
        end
        default: begin // illegal encoding
            e.period    = 8;
            e.pcWrites  = 2;
            e.jumpSrc   = pcExcVector;
            e.epcWrites = 1;
            e.epcAddr   = adrIllegalVec;
            e.mdrLoads  = 1;
        end
    endcase
    // addiu never traps
    if (ovf && (cls == clsAdd || cls == clsAddi)) begin
        e.period    = 9;
        e.regWrites = 0;
        e.regDst    = dstRt;
        e.pcWrites  = 2;
        e.jumpSrc   = pcExcVector;
        e.epcWrites = 1;
        e.epcAddr   = adrOverflowVec;
        e.mdrLoads  = 1;
    end
    return e;
endfunction

`endif

/* bench/mipsControlTb.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsControlTb import isaPkg::*, ctrlPkg::*; ();

    localparam int MultCycles     = 5;
    localparam int NumInstr       = 60;
    localparam int WatchdogCycles = NumInstr * (6 + MultCycles + 10) + 8;

    `include "ctrlRefModel.svh"

    logic       clk;
    logic       rstN;
    logic [5:0] opcode;
    logic [5:0] funct;
    logic       overflow;

    logic       pcWrite, pcWriteCond, memWrite, irWrite, regWrite;
    logic       regALoad, regBLoad, aluSrcA, epcWrite, aluOutWrite;
    logic       mdrLoad, hiLoWrite, multInit;
    regDstE     regDst;
    aluSrcBE    aluSrcB;
    iorDE       iorD;
    aluOpE      aluOp;
    pcSrcE      pcSrc;
    memToRegE   memToReg;
    branchCondE branchCond;

    integer      seed;
    int          issued;
    int          pick;
    logic [31:0] rnd;
    instrClassE  nextClass;
    logic [11:0] nextWord;
    logic        nextOvf;
    instrClassE  stimClass; // instruction currently held on the inputs
    logic        stimOvf;

    int     sinceReset;
    int     cycle;
    int     multAt;
    int     doneCount;
    bit     inFlight;
    expectT seen;

    mipsControl #(.MultCycles(MultCycles)) mipsControl_inst (
        .clk         (clk),
        .rstN        (rstN),
        .opcode      (opcode),
        .funct       (funct),
        .overflow    (overflow),
        .pcWrite     (pcWrite),
        .pcWriteCond (pcWriteCond),
        .memWrite    (memWrite),
        .irWrite     (irWrite),
        .regWrite    (regWrite),
        .regALoad    (regALoad),
        .regBLoad    (regBLoad),
        .aluSrcA     (aluSrcA),
        .epcWrite    (epcWrite),
        .aluOutWrite (aluOutWrite),
        .mdrLoad     (mdrLoad),
        .hiLoWrite   (hiLoWrite),
        .multInit    (multInit),
        .regDst      (regDst),
        .aluSrcB     (aluSrcB),
        .iorD        (iorD),
        .aluOp       (aluOp),
        .pcSrc       (pcSrc),
        .memToReg    (memToReg),
        .branchCond  (branchCond)
    );

    always #4 clk = ~clk;

    initial begin
        clk        = 1'b0;
        rstN       = 1'b0;
        opcode     = 6'h00;
        funct      = 6'h00;
        overflow   = 1'b0;
        seed       = 25876;
        issued     = 0;
        stimClass  = clsIllegal;
        stimOvf    = 1'b0;
        sinceReset = 0;
        cycle      = 0;
        multAt     = 0;
        doneCount  = 0;
        inFlight   = 1'b0;
        seen       = blankRecord();
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
    end

    task automatic checkValue(string name, int expected, int actual);
        if (expected != actual) begin
            $display("Mismatch at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
            $display("*** FAILED ***");
            $fatal(1, "control sequence differs from the reference");
        end
    endtask

    function automatic logic [11:0] encodeInstr(instrClassE cls, logic [31:0] r);
        logic [11:0] bad [8];
        bad = '{12'h040, 12'h3C0, 12'h800, 12'hFC0,  // regimm, lui, lb, unused
                12'h000, 12'h01A, 12'h010, 12'h00D}; // sll, div, mfhi, break
        case (cls)
            clsAdd:   return {opRType, fnAdd};
            clsMult:  return {opRType, fnMult};
            clsJr:    return {opRType, fnJr};
            clsAddi:  return {opAddi, r[5:0]}; // low imm bits share the funct field
            clsAddiu: return {opAddiu, r[5:0]};
            clsLw:    return {opLw, r[5:0]};
            clsSw:    return {opSw, r[5:0]};
            clsBeq:   return {opBeq, r[5:0]};
            clsBne:   return {opBne, r[5:0]};
            clsBgt:   return {opBgt, r[5:0]};
            clsBle:   return {opBle, r[5:0]};
            clsJ:     return {opJ, r[5:0]};
            clsJal:   return {opJal, r[5:0]};
            default:  return bad[r[8:6]];
        endcase
    endfunction

    task automatic compareInstr(string cls, expectT exp, expectT got);
        checkValue({cls, " period"}, exp.period, got.period);
        checkValue({cls, " regWrite count"}, exp.regWrites, got.regWrites);
        if (exp.regWrites > 0) begin
            checkValue({cls, " regDst"}, int'(exp.regDst), int'(got.regDst));
            checkValue({cls, " memToReg"}, int'(exp.memToReg), int'(got.memToReg));
        end
        checkValue({cls, " memWrite count"}, exp.memWrites, got.memWrites);
        checkValue({cls, " pcWrite count"}, exp.pcWrites, got.pcWrites);
        checkValue({cls, " pcSrc"}, int'(exp.jumpSrc), int'(got.jumpSrc));
        checkValue({cls, " pcWriteCond count"}, exp.condWrites, got.condWrites);
        if (exp.condWrites > 0) begin
            checkValue({cls, " branchCond"}, int'(exp.branchCond), int'(got.branchCond));
            checkValue({cls, " aluOp"}, int'(exp.branchAluOp), int'(got.branchAluOp));
        end
        checkValue({cls, " epcWrite count"}, exp.epcWrites, got.epcWrites);
        if (exp.epcWrites > 0) begin
            checkValue({cls, " iorD"}, int'(exp.epcAddr), int'(got.epcAddr));
        end
        checkValue({cls, " multInit count"}, exp.multInits, got.multInits);
        checkValue({cls, " hiLoWrite count"}, exp.hiLoWrites, got.hiLoWrites);
        checkValue({cls, " hiLoWrite delay"}, exp.hiLoDelay, got.hiLoDelay);
        checkValue({cls, " regALoad count"}, exp.aLoads, got.aLoads);
        checkValue({cls, " regBLoad count"}, exp.bLoads, got.bLoads);
        checkValue({cls, " aluSrcA count"}, exp.srcASelects, got.srcASelects);
        checkValue({cls, " aluOutWrite count"}, exp.aluOutWrites, got.aluOutWrites);
        checkValue({cls, " aluSrcB"}, int'(exp.aluOutSrcB), int'(got.aluOutSrcB));
        checkValue({cls, " mdrLoad count"}, exp.mdrLoads, got.mdrLoads);
    endtask

    // next instruction goes on the inputs right after the ir is loaded
    always @(posedge clk) begin
        if (rstN && irWrite && issued < NumInstr) begin
            pick      = $unsigned($random(seed)) % 14;
            nextClass = instrClassE'(pick[3:0]);
            rnd       = $random(seed);
            nextWord  = encodeInstr(nextClass, rnd);
            rnd       = $random(seed);
            nextOvf   = rnd[0];
            opcode    <= nextWord[11:6];
            funct     <= nextWord[5:0];
            overflow  <= nextOvf;
            stimClass <= nextClass;
            stimOvf   <= nextOvf;
            issued    <= issued + 1;
        end
    end

    always @(posedge clk) begin
        if (rstN) begin
            sinceReset = sinceReset + 1;
            if (sinceReset == 1) begin // sp init
                checkValue("regWrite", 1, int'(regWrite));
                checkValue("regDst", int'(dstSp), int'(regDst));
                checkValue("memToReg", int'(wbSpInit), int'(memToReg));
            end
            if (sinceReset == 2) begin
                checkValue("pcWrite", 1, int'(pcWrite));
                checkValue("pcSrc", int'(pcAluResult), int'(pcSrc));
            end
            if (sinceReset == 3)
                checkValue("irWrite", 0, int'(irWrite));
            if (sinceReset == 4)
                checkValue("irWrite", 1, int'(irWrite));
            if (irWrite) begin
                if (inFlight) begin
                    seen.period = cycle + 1;
                    compareInstr(stimClass.name(), expectedFor(stimClass, stimOvf, MultCycles),
                                 seen);
                    doneCount = doneCount + 1;
                end
                seen     = blankRecord();
                inFlight = 1'b1;
                cycle    = 0;
                multAt   = 0;
            end else if (inFlight) begin
                cycle = cycle + 1;
                if (regWrite) begin
                    seen.regWrites = seen.regWrites + 1;
                    seen.regDst    = regDst;
                    seen.memToReg  = memToReg;
                end
                if (memWrite) begin
                    seen.memWrites = seen.memWrites + 1;
                    checkValue("iorD at memWrite", int'(adrAluOut), int'(iorD));
                end
                if (pcWrite) begin
                    if (seen.pcWrites == 0)
                        seen.jumpSrc = pcSrc;
                    seen.pcWrites = seen.pcWrites + 1;
                end
                if (pcWriteCond) begin
                    seen.condWrites  = seen.condWrites + 1;
                    seen.branchCond  = branchCond;
                    seen.branchAluOp = aluOp;
                end
                if (epcWrite) begin
                    seen.epcWrites = seen.epcWrites + 1;
                    seen.epcAddr   = iorD;
                end
                if (multInit) begin
                    seen.multInits = seen.multInits + 1;
                    multAt         = cycle;
                end
                if (hiLoWrite) begin
                    seen.hiLoWrites = seen.hiLoWrites + 1;
                    seen.hiLoDelay  = cycle - multAt;
                end
                if (regALoad)
                    seen.aLoads = seen.aLoads + 1;
                if (regBLoad)
                    seen.bLoads = seen.bLoads + 1;
                if (aluSrcA)
                    seen.srcASelects = seen.srcASelects + 1;
                if (aluOutWrite) begin
                    seen.aluOutWrites = seen.aluOutWrites + 1;
                    seen.aluOutSrcB   = aluSrcB;
                end
                if (mdrLoad)
                    seen.mdrLoads = seen.mdrLoads + 1;
            end
        end
    end

    initial begin
        wait (doneCount == NumInstr);
        $display("*** PASSED ***");
        $finish;
    end

    // longest instruction plus margin, for every instruction
    initial begin
        repeat (WatchdogCycles) @(posedge clk);
        $display("Run timed out after %0d cycles with %0d instructions checked",
                 WatchdogCycles, doneCount);
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

/* mipsControl.f */
+incdir+bench
rtl/isaPkg.sv
rtl/ctrlPkg.sv
rtl/ctrlWordIf.sv
rtl/instrDecoder.sv
rtl/stateSequencer.sv
rtl/controlWordGen.sv
rtl/mipsControl.sv
bench/mipsControlTb.sv

/* rtl/controlWordGen.sv */
`timescale 1ns/1ps
`default_nettype none

module controlWordGen import ctrlPkg::*; (
    input  wire stateE state,
    ctrlWordIf.gen     ctrl
);

    always_comb begin
        ctrl.pcWrite     = 1'b0;
        ctrl.pcWriteCond = 1'b0;
        ctrl.memWrite    = 1'b0;
        ctrl.irWrite     = 1'b0;
        ctrl.regWrite    = 1'b0;
        ctrl.regALoad    = 1'b0;
        ctrl.regBLoad    = 1'b0;
        ctrl.aluSrcA     = 1'b0;
        ctrl.epcWrite    = 1'b0;
        ctrl.aluOutWrite = 1'b0;
        ctrl.mdrLoad     = 1'b0;
        ctrl.hiLoWrite   = 1'b0;
        ctrl.multInit    = 1'b0;
        ctrl.regDst      = dstRt;
        ctrl.aluSrcB     = srcBRegB;
        ctrl.iorD        = adrPc;
        ctrl.aluOp       = aluPass;
        ctrl.pcSrc       = pcAluResult;
        ctrl.memToReg    = wbAluOut;
        ctrl.branchCond  = brNone;

        case (state)
            resetInit: begin // load sp with its init value
                ctrl.regWrite = 1'b1;
                ctrl.regDst   = dstSp;
                ctrl.memToReg = wbSpInit;
            end
            fetchPc: begin // pc <= pc + 4
                ctrl.pcWrite = 1'b1;
                ctrl.aluSrcB = srcBFour;
                ctrl.aluOp   = aluAdd;
            end
            fetchIr: ctrl.irWrite = 1'b1;
            decode: begin // branch target precomputed into aluOut
                ctrl.regALoad    = 1'b1;
                ctrl.regBLoad    = 1'b1;
                ctrl.aluOutWrite = 1'b1;
                ctrl.aluSrcB     = srcBBranchOff;
                ctrl.aluOp       = aluAdd;
            end
            addExec, addiExec, memAddr: begin
                ctrl.aluSrcA     = 1'b1;
                ctrl.aluOp       = aluAdd;
                ctrl.aluOutWrite = 1'b1;
                ctrl.aluSrcB     = (state == addExec) ? srcBRegB : srcBImm;
            end
            addWrite: begin
                ctrl.regWrite = 1'b1;
                ctrl.regDst   = dstRd;
            end
            addiWrite: ctrl.regWrite = 1'b1; // rt, aluOut
            memRead, memWait: ctrl.iorD = adrAluOut;
            memWrite: begin
                ctrl.memWrite = 1'b1;
                ctrl.iorD     = adrAluOut;
            end
            mdrLoad, excLoad: ctrl.mdrLoad = 1'b1;
            loadWrite: begin
                ctrl.regWrite = 1'b1;
                ctrl.memToReg = wbMdr;
            end
            branchEq, branchNe, branchGt, branchLe: begin
                ctrl.pcWriteCond = 1'b1;
                ctrl.aluSrcA     = 1'b1;
                ctrl.pcSrc       = pcAluOut;
                case (state)
                    branchEq: ctrl.branchCond = brEq;
                    branchNe: ctrl.branchCond = brNe;
                    branchGt: ctrl.branchCond = brGt;
                    default:  ctrl.branchCond = brLe;
                endcase
                ctrl.aluOp = (state == branchEq || state == branchNe) ? aluSub : aluCompare;
            end
            linkWrite: begin
                ctrl.regWrite = 1'b1;
                ctrl.regDst   = dstRa;
                ctrl.memToReg = wbPcLink;
            end
            jump: begin
                ctrl.pcWrite = 1'b1;
                ctrl.pcSrc   = pcJumpTarget;
            end
            jumpReg: begin // rs passes straight through the alu
                ctrl.pcWrite = 1'b1;
                ctrl.aluSrcA = 1'b1;
            end
            multStart: ctrl.multInit  = 1'b1;
            hiLoWrite: ctrl.hiLoWrite = 1'b1;
            excSaveOvf, excSaveIll: begin // epc <= pc - 4, fetch vector
                ctrl.epcWrite = 1'b1;
                ctrl.aluSrcB  = srcBFour;
                ctrl.aluOp    = aluSub;
                ctrl.iorD     = (state == excSaveOvf) ? adrOverflowVec : adrIllegalVec;
            end
            excJump: begin
                ctrl.pcWrite = 1'b1;
                ctrl.pcSrc   = pcExcVector;
            end
            default: ;
        endcase
    end

    // pc has a single write port
    always_comb begin
        assert (!(ctrl.pcWrite && ctrl.pcWriteCond));
    end

endmodule

`default_nettype wire

/* rtl/ctrlPkg.sv */
`default_nettype none

package ctrlPkg;

    typedef enum logic [4:0] {
        resetInit,
        fetchPc, fetchWait, fetchIr, decode,
        addExec, addWrite, addiExec, addiWrite,
        memAddr, memWrite, memRead, memWait, mdrLoad, loadWrite,
        branchEq, branchNe, branchGt, branchLe, // one per condition, keeps outputs Moore
        linkWrite, jump, jumpReg,
        multStart, multWait, hiLoWrite,
        excSaveOvf, excSaveIll, excWait, excLoad, excJump
    } stateE;

    typedef enum logic [2:0] {
        aluPass    = 3'd0,
        aluAdd     = 3'd1,
        aluSub     = 3'd2,
        aluCompare = 3'd7
    } aluOpE;

    typedef enum logic [2:0] {
        pcAluResult  = 3'd0,
        pcAluOut     = 3'd1,
        pcJumpTarget = 3'd2,
        pcExcVector  = 3'd3
    } pcSrcE;

    typedef enum logic [1:0] {
        dstRt = 2'd0,
        dstRd = 2'd1,
        dstRa = 2'd2,
        dstSp = 2'd3 // $29, used once after reset
    } regDstE;

    typedef enum logic [2:0] {
        wbAluOut = 3'd0,
        wbMdr    = 3'd1,
        wbPcLink = 3'd6,
        wbSpInit = 3'd7
    } memToRegE;

    typedef enum logic [1:0] {
        adrPc          = 2'd0,
        adrAluOut      = 2'd1,
        adrIllegalVec  = 2'd2,
        adrOverflowVec = 2'd3
    } iorDE;

    typedef enum logic [1:0] {
        srcBRegB      = 2'd0,
        srcBFour      = 2'd1,
        srcBImm       = 2'd2,
        srcBBranchOff = 2'd3 // sign-extended imm << 2
    } aluSrcBE;

    typedef enum logic [2:0] {
        brNone,
        brEq,
        brNe,
        brGt,
        brLe
    } branchCondE;

endpackage

`default_nettype wire

/* rtl/ctrlWordIf.sv */
`timescale 1ns/1ps
`default_nettype none

interface ctrlWordIf import ctrlPkg::*; ();

    logic pcWrite, pcWriteCond, memWrite, irWrite, regWrite;
    logic regALoad, regBLoad, aluSrcA, epcWrite, aluOutWrite;
    logic mdrLoad, hiLoWrite, multInit;

    regDstE     regDst;
    aluSrcBE    aluSrcB;
    iorDE       iorD;
    aluOpE      aluOp;
    pcSrcE      pcSrc;
    memToRegE   memToReg;
    branchCondE branchCond;

    modport gen (
        output pcWrite, pcWriteCond, memWrite, irWrite, regWrite,
        output regALoad, regBLoad, aluSrcA, epcWrite, aluOutWrite,
        output mdrLoad, hiLoWrite, multInit,
        output regDst, aluSrcB, iorD, aluOp, pcSrc, memToReg, branchCond
    );

    modport sink (
        input pcWrite, pcWriteCond, memWrite, irWrite, regWrite,
        input regALoad, regBLoad, aluSrcA, epcWrite, aluOutWrite,
        input mdrLoad, hiLoWrite, multInit,
        input regDst, aluSrcB, iorD, aluOp, pcSrc, memToReg, branchCond
    );

endinterface

`default_nettype wire

/* rtl/instrDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instrDecoder import isaPkg::*; (
    input  wire opcodeE     opcode,
    input  wire functE      funct,
    output instrClassE      instrClass
);

    always_comb begin
        instrClass = clsIllegal; // anything not matched below
        case (opcode)
            opRType: begin
                case (funct)
                    fnAdd:   instrClass = clsAdd;
                    fnMult:  instrClass = clsMult;
                    fnJr:    instrClass = clsJr;
                    default: instrClass = clsIllegal;
                endcase
            end
            opAddi:  instrClass = clsAddi;
            opAddiu: instrClass = clsAddiu;
            opLw:    instrClass = clsLw;
            opSw:    instrClass = clsSw;
            opBeq:   instrClass = clsBeq;
            opBne:   instrClass = clsBne;
            opBgt:   instrClass = clsBgt;
            opBle:   instrClass = clsBle;
            opJ:     instrClass = clsJ;
            opJal:   instrClass = clsJal;
            default: instrClass = clsIllegal;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/isaPkg.sv */
`default_nettype none

package isaPkg;

    // primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        opRType = 6'h00,
        opJ     = 6'h02,
        opJal   = 6'h03,
        opBeq   = 6'h04,
        opBne   = 6'h05,
        opBle   = 6'h06,
        opBgt   = 6'h07,
        opAddi  = 6'h08,
        opAddiu = 6'h09,
        opLw    = 6'h23,
        opSw    = 6'h2B
    } opcodeE;

    // funct field, only meaningful with opRType
    typedef enum logic [5:0] {
        fnJr   = 6'h08,
        fnMult = 6'h18,
        fnAdd  = 6'h20
    } functE;

    typedef enum logic [3:0] {
        clsAdd,
        clsAddi,
        clsAddiu,
        clsLw,
        clsSw,
        clsBeq,
        clsBne,
        clsBgt,
        clsBle,
        clsJ,
        clsJal,
        clsJr,
        clsMult,
        clsIllegal
    } instrClassE;

endpackage

`default_nettype wire

/* rtl/mipsControl.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsControl import isaPkg::*, ctrlPkg::*; #(
    parameter int MultCycles = 33
) (
    input  wire        clk,
    input  wire        rstN,
    input  wire [5:0]  opcode,
    input  wire [5:0]  funct,
    input  wire        overflow,
    output logic       pcWrite,
    output logic       pcWriteCond,
    output logic       memWrite,
    output logic       irWrite,
    output logic       regWrite,
    output logic       regALoad,
    output logic       regBLoad,
    output logic       aluSrcA,
    output logic       epcWrite,
    output logic       aluOutWrite,
    output logic       mdrLoad,
    output logic       hiLoWrite,
    output logic       multInit,
    output regDstE     regDst,
    output aluSrcBE    aluSrcB,
    output iorDE       iorD,
    output aluOpE      aluOp,
    output pcSrcE      pcSrc,
    output memToRegE   memToReg,
    output branchCondE branchCond
);

    opcodeE     opcodeIn;
    functE      functIn;
    instrClassE instrClass;
    stateE      state;

    ctrlWordIf ctrlBus ();

    assign opcodeIn = opcodeE'(opcode); // raw ir bits, unlisted codes decode as illegal
    assign functIn  = functE'(funct);

    instrDecoder instrDecoderInst (
        .opcode     (opcodeIn),
        .funct      (functIn),
        .instrClass (instrClass)
    );

    stateSequencer #(.MultCycles(MultCycles)) stateSequencerInst (
        .clk        (clk),
        .rstN       (rstN),
        .instrClass (instrClass),
        .overflow   (overflow),
        .state      (state)
    );

    controlWordGen controlWordGenInst (
        .state (state),
        .ctrl  (ctrlBus.gen)
    );

    assign pcWrite     = ctrlBus.pcWrite;
    assign pcWriteCond = ctrlBus.pcWriteCond;
    assign memWrite    = ctrlBus.memWrite;
    assign irWrite     = ctrlBus.irWrite;
    assign regWrite    = ctrlBus.regWrite;
    assign regALoad    = ctrlBus.regALoad;
    assign regBLoad    = ctrlBus.regBLoad;
    assign aluSrcA     = ctrlBus.aluSrcA;
    assign epcWrite    = ctrlBus.epcWrite;
    assign aluOutWrite = ctrlBus.aluOutWrite;
    assign mdrLoad     = ctrlBus.mdrLoad;
    assign hiLoWrite   = ctrlBus.hiLoWrite;
    assign multInit    = ctrlBus.multInit;
    assign regDst      = ctrlBus.regDst;
    assign aluSrcB     = ctrlBus.aluSrcB;
    assign iorD        = ctrlBus.iorD;
    assign aluOp       = ctrlBus.aluOp;
    assign pcSrc       = ctrlBus.pcSrc;
    assign memToReg    = ctrlBus.memToReg;
    assign branchCond  = ctrlBus.branchCond;

endmodule

`default_nettype wire

/* rtl/stateSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module stateSequencer import isaPkg::*, ctrlPkg::*; #(
    parameter int MultCycles = 33
) (
    input  wire             clk,
    input  wire             rstN,
    input  wire instrClassE instrClass,
    input  wire             overflow,
    output stateE           state
);

    stateE      nextState;
    logic [6:0] waitCnt;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= resetInit;
        end else begin
            state <= nextState;
        end
    end

    // multiply latency counter
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            waitCnt <= '0;
        end else if (state == multStart) begin
            waitCnt <= 7'(MultCycles);
        end else if (state == multWait && waitCnt != '0) begin
            waitCnt <= waitCnt - 7'd1;
        end
    end

    always_comb begin
        nextState = resetInit;
        case (state)
            resetInit: nextState = fetchPc;
            fetchPc:   nextState = fetchWait;
            fetchWait: nextState = fetchIr;
            fetchIr:   nextState = decode;
            decode: begin
                case (instrClass)
                    clsAdd:   nextState = addExec;
                    clsAddi:  nextState = addiExec;
                    clsAddiu: nextState = addiExec;
                    clsLw:    nextState = memAddr;
                    clsSw:    nextState = memAddr;
                    clsBeq:   nextState = branchEq;
                    clsBne:   nextState = branchNe;
                    clsBgt:   nextState = branchGt;
                    clsBle:   nextState = branchLe;
                    clsJ:     nextState = jump;
                    clsJal:   nextState = linkWrite;
                    clsJr:    nextState = jumpReg;
                    clsMult:  nextState = multStart;
                    default:  nextState = excSaveIll;
                endcase
            end
            addExec:  nextState = overflow ? excSaveOvf : addWrite;
            // addiu shares the datapath but never traps
            addiExec: nextState = (instrClass == clsAddi && overflow) ? excSaveOvf : addiWrite;
            memAddr:  nextState = (instrClass == clsSw) ? memWrite : memRead;
            memRead:  nextState = memWait;
            memWait:  nextState = mdrLoad;
            mdrLoad:  nextState = loadWrite;
            linkWrite: nextState = jump;
            multStart: nextState = multWait;
            multWait:  nextState = (waitCnt == 7'd1) ? hiLoWrite : multWait;
            excSaveOvf, excSaveIll: nextState = excWait;
            excWait:  nextState = excLoad;
            excLoad:  nextState = excJump;
            addWrite, addiWrite, memWrite, loadWrite,
            branchEq, branchNe, branchGt, branchLe,
            jump, jumpReg, hiLoWrite, excJump: nextState = fetchPc;
            default:  nextState = resetInit;
        endcase
    end

    counterBound: assert property (@(posedge clk) disable iff (!rstN)
        waitCnt <= 7'(MultCycles));

    multWaitEntry: assert property (@(posedge clk) disable iff (!rstN)
        (state == multStart) |=> (state == multWait && waitCnt != '0));

endmodule

`default_nettype wire

/* runSim.sh */
#!/bin/sh
# build and run the control unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module mipsControlTb -f mipsControl.f \
    -o mipsControlSim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/mipsControlSim > sim.log 2>&1
cat sim.log
grep -q '\*\*\* FAILED \*\*\*' sim.log && exit 1
grep -q '\*\*\* PASSED \*\*\*' sim.log || exit 1
